/* Bender.yml */
package:
  name: soc_periph

sources:
  - hw/soc_periph_pkg.sv
  - hw/periph_decode.sv
  - hw/clint_timer.sv
  - hw/plic_gateway.sv
  - hw/periph_result.sv
  - hw/soc_periph_top.sv
  - target: test
    files:
      - test/tb_soc_periph.sv

/* hw/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer #(
    parameter int TICK_DIV = 4
) (
    input wire clk,
    input wire rst_n_i,
    input wire soc_periph_pkg::periph_req_t req_i,
    input wire req_valid_i,
    output soc_periph_pkg::periph_rsp_t rsp_o,
    output logic rsp_valid_o,
    output logic timer_irq_o,
    output logic soft_irq_o
);

    localparam int DATA_W = soc_periph_pkg::DATA_W;
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic tick;
    logic msip_q;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic hit;
    logic [DATA_W-1:0] rd_data;
    logic rd_err;

    assign tick = (cnt_q == CNT_W'(TICK_DIV - 1));
    assign hit = req_valid_i && (req_i.unit == soc_periph_pkg::UNIT_CLINT);

    always_comb begin
        rd_data = '0;
        rd_err = 1'b0;
        case (req_i.op)
            soc_periph_pkg::OP_MSIP: rd_data = {{(DATA_W-1){1'b0}}, msip_q};
            soc_periph_pkg::OP_MTIMECMP_LO: rd_data = mtimecmp_q[31:0];
            soc_periph_pkg::OP_MTIMECMP_HI: rd_data = mtimecmp_q[63:32];
            soc_periph_pkg::OP_MTIME_LO: rd_data = mtime_q[31:0];
            soc_periph_pkg::OP_MTIME_HI: rd_data = mtime_q[63:32];
            default: rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            msip_q <= 1'b0;
            mtime_q <= '0;
            mtimecmp_q <= '1;
            rsp_valid_o <= 1'b0;
            timer_irq_o <= 1'b0;
            soft_irq_o <= 1'b0;
        end else begin
            cnt_q <= tick ? '0 : cnt_q + 1'b1;
            if (tick) begin
                mtime_q <= mtime_q + 64'd1;
            end
            rsp_valid_o <= hit;
            timer_irq_o <= (mtime_q >= mtimecmp_q);
            soft_irq_o <= msip_q;
            // A write to mtime assigns all 64 bits, so it replaces the tick.
            if (hit && req_i.write) begin
                case (req_i.op)
                    soc_periph_pkg::OP_MSIP: begin
                        if (req_i.wstrb[0]) begin
                            msip_q <= req_i.wdata[0];
                        end
                    end
                    soc_periph_pkg::OP_MTIMECMP_LO: mtimecmp_q[31:0] <=
                        soc_periph_pkg::apply_strb(mtimecmp_q[31:0], req_i.wdata, req_i.wstrb);
                    soc_periph_pkg::OP_MTIMECMP_HI: mtimecmp_q[63:32] <=
                        soc_periph_pkg::apply_strb(mtimecmp_q[63:32], req_i.wdata, req_i.wstrb);
                    soc_periph_pkg::OP_MTIME_LO: mtime_q <= {mtime_q[63:32],
                        soc_periph_pkg::apply_strb(mtime_q[31:0], req_i.wdata, req_i.wstrb)};
                    soc_periph_pkg::OP_MTIME_HI: mtime_q <= {
                        soc_periph_pkg::apply_strb(mtime_q[63:32], req_i.wdata, req_i.wstrb),
                        mtime_q[31:0]};
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rsp_o.rdata <= rd_data;
            rsp_o.err <= rd_err;
        end
    end

endmodule

`default_nettype wire

/* hw/periph_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_decode (
    input wire clk,
    input wire rst_n_i,
    input wire soc_periph_pkg::axil_req_t axil_req_i,
    output logic aw_ready_o,
    output logic w_ready_o,
    output logic ar_ready_o,
    input wire done_i,
    output soc_periph_pkg::periph_req_t req_o,
    output logic req_valid_o
);

    localparam int ADDR_W = soc_periph_pkg::ADDR_W;
    localparam int OFS_W = soc_periph_pkg::OFS_W;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT
    } state_e;

    state_e state_q;
    logic wr_accept;
    logic rd_accept;
    logic [ADDR_W-1:0] acc_addr;
    soc_periph_pkg::periph_unit_e acc_unit;
    soc_periph_pkg::periph_op_e acc_op;
    soc_periph_pkg::periph_req_t req_q;

    // A write needs both AW and W present, and any write activity blocks a read.
    assign aw_ready_o = (state_q == IDLE) && axil_req_i.aw_valid && axil_req_i.w_valid;
    assign w_ready_o = aw_ready_o;
    assign ar_ready_o = (state_q == IDLE) && !axil_req_i.aw_valid && !axil_req_i.w_valid;

    assign wr_accept = aw_ready_o;
    assign rd_accept = ar_ready_o && axil_req_i.ar_valid;
    assign acc_addr = wr_accept ? axil_req_i.aw_addr : axil_req_i.ar_addr;

    always_comb begin
        acc_unit = soc_periph_pkg::UNIT_NONE;
        acc_op = soc_periph_pkg::OP_INVALID;
        if (acc_addr[ADDR_W-1:OFS_W] == soc_periph_pkg::CLINT_BASE[ADDR_W-1:OFS_W]) begin
            acc_unit = soc_periph_pkg::UNIT_CLINT;
            case (acc_addr[OFS_W-1:0])
                soc_periph_pkg::OFS_MSIP: acc_op = soc_periph_pkg::OP_MSIP;
                soc_periph_pkg::OFS_MTIMECMP_LO: acc_op = soc_periph_pkg::OP_MTIMECMP_LO;
                soc_periph_pkg::OFS_MTIMECMP_HI: acc_op = soc_periph_pkg::OP_MTIMECMP_HI;
                soc_periph_pkg::OFS_MTIME_LO: acc_op = soc_periph_pkg::OP_MTIME_LO;
                soc_periph_pkg::OFS_MTIME_HI: acc_op = soc_periph_pkg::OP_MTIME_HI;
                default: acc_op = soc_periph_pkg::OP_INVALID;
            endcase
        end else if (acc_addr[ADDR_W-1:OFS_W] == soc_periph_pkg::PLIC_BASE[ADDR_W-1:OFS_W]) begin
            acc_unit = soc_periph_pkg::UNIT_PLIC;
            case (acc_addr[OFS_W-1:0])
                soc_periph_pkg::OFS_PENDING: acc_op = soc_periph_pkg::OP_PENDING;
                soc_periph_pkg::OFS_ENABLE: acc_op = soc_periph_pkg::OP_ENABLE;
                soc_periph_pkg::OFS_CLAIM: acc_op = soc_periph_pkg::OP_CLAIM;
                default: acc_op = soc_periph_pkg::OP_INVALID;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state_q <= ISSUE;
                    end
                end
                ISSUE: state_q <= WAIT;
                WAIT: begin
                    if (done_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept || rd_accept) begin
            req_q.unit <= acc_unit;
            req_q.op <= acc_op;
            req_q.write <= wr_accept;
            req_q.wdata <= wr_accept ? axil_req_i.w_data : '0;
            req_q.wstrb <= wr_accept ? axil_req_i.w_strb : '0;
        end
    end

    assign req_o = req_q;
    assign req_valid_o = (state_q == ISSUE);

endmodule

`default_nettype wire

/* hw/periph_result.sv */
`timescale 1ns/1ps
`default_nettype none

module periph_result (
    input wire clk,
    input wire rst_n_i,
    input wire soc_periph_pkg::periph_req_t req_i,
    input wire req_valid_i,
    input wire soc_periph_pkg::periph_rsp_t clint_rsp_i,
    input wire clint_rsp_valid_i,
    input wire soc_periph_pkg::periph_rsp_t plic_rsp_i,
    input wire plic_rsp_valid_i,
    input wire b_ready_i,
    input wire r_ready_i,
    output logic b_valid_o,
    output soc_periph_pkg::axi_resp_e b_resp_o,
    output logic r_valid_o,
    output logic [soc_periph_pkg::DATA_W-1:0] r_data_o,
    output soc_periph_pkg::axi_resp_e r_resp_o,
    output logic done_o
);

    soc_periph_pkg::periph_unit_e unit_q;
    logic write_q;
    logic none_valid_q;
    logic rsp_valid;
    soc_periph_pkg::periph_rsp_t unit_rsp;
    soc_periph_pkg::axi_resp_e resp;

    // An unmapped access gets its answer on the same cycle a unit would.
    assign rsp_valid = clint_rsp_valid_i || plic_rsp_valid_i || none_valid_q;
    assign unit_rsp = (unit_q == soc_periph_pkg::UNIT_PLIC) ? plic_rsp_i : clint_rsp_i;

    always_comb begin
        if (unit_q == soc_periph_pkg::UNIT_NONE) begin
            resp = soc_periph_pkg::RESP_DECERR;
        end else if (unit_rsp.err) begin
            resp = soc_periph_pkg::RESP_SLVERR;
        end else begin
            resp = soc_periph_pkg::RESP_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            none_valid_q <= 1'b0;
            b_valid_o <= 1'b0;
            r_valid_o <= 1'b0;
        end else begin
            none_valid_q <= req_valid_i && (req_i.unit == soc_periph_pkg::UNIT_NONE);
            if (rsp_valid && write_q) begin
                b_valid_o <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_o <= 1'b0;
            end
            if (rsp_valid && !write_q) begin
                r_valid_o <= 1'b1;
            end else if (r_ready_i) begin
                r_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i) begin
            unit_q <= req_i.unit;
            write_q <= req_i.write;
        end
        if (rsp_valid) begin
            b_resp_o <= resp;
            r_resp_o <= resp;
            r_data_o <= (resp == soc_periph_pkg::RESP_OKAY) ? unit_rsp.rdata : '0;
        end
    end

    assign done_o = (b_valid_o && b_ready_i) || (r_valid_o && r_ready_i);

endmodule

`default_nettype wire

/* hw/plic_gateway.sv */
`timescale 1ns/1ps
`default_nettype none

module plic_gateway #(
    parameter int N_SOURCES = 8
) (
    input wire clk,
    input wire rst_n_i,
    input wire soc_periph_pkg::periph_req_t req_i,
    input wire req_valid_i,
    output soc_periph_pkg::periph_rsp_t rsp_o,
    output logic rsp_valid_o,
    input wire [N_SOURCES-1:0] src_i,
    output logic ext_irq_o
);

    localparam int DATA_W = soc_periph_pkg::DATA_W;

    // Bit k-1 of these vectors belongs to source id k.
    logic [N_SOURCES-1:0] pending_q;
    logic [N_SOURCES-1:0] enable_q;
    logic [N_SOURCES-1:0] in_service_q;
    logic [N_SOURCES-1:0] in_service_d;
    logic [N_SOURCES-1:0] pend_en;
    logic [N_SOURCES-1:0] claim_oh;
    logic [N_SOURCES-1:0] complete_oh;
    logic [DATA_W-1:0] claim_id;
    logic [DATA_W-1:0] pend_word;
    logic [DATA_W-1:0] en_word;
    logic [DATA_W-1:0] en_new;
    logic hit;
    logic do_claim;
    logic do_complete;
    logic [DATA_W-1:0] rd_data;
    logic rd_err;

    assign hit = req_valid_i && (req_i.unit == soc_periph_pkg::UNIT_PLIC);
    assign do_claim = hit && !req_i.write && (req_i.op == soc_periph_pkg::OP_CLAIM);
    assign do_complete = hit && req_i.write && (req_i.op == soc_periph_pkg::OP_CLAIM);

    assign pend_en = pending_q & enable_q;
    // Isolate the lowest set bit, which is the lowest claimable id.
    assign claim_oh = pend_en & (~pend_en + 1'b1);

    always_comb begin
        claim_id = '0;
        for (int k = N_SOURCES - 1; k >= 0; k--) begin
            if (pend_en[k]) begin
                claim_id = k + 1;
            end
        end
        for (int k = 0; k < N_SOURCES; k++) begin
            complete_oh[k] = (req_i.wdata == k + 1);
        end
        pend_word = '0;
        pend_word[N_SOURCES:1] = pending_q;
        en_word = '0;
        en_word[N_SOURCES:1] = enable_q;
        en_new = soc_periph_pkg::apply_strb(en_word, req_i.wdata, req_i.wstrb);
    end

    always_comb begin
        in_service_d = in_service_q;
        if (do_claim) begin
            in_service_d = in_service_q | claim_oh;
        end else if (do_complete) begin
            in_service_d = in_service_q & ~complete_oh;
        end
    end

    always_comb begin
        rd_data = '0;
        rd_err = 1'b0;
        case (req_i.op)
            soc_periph_pkg::OP_PENDING: begin
                rd_data = pend_word;
                rd_err = req_i.write;
            end
            soc_periph_pkg::OP_ENABLE: rd_data = en_word;
            soc_periph_pkg::OP_CLAIM: rd_data = claim_id;
            default: rd_err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q <= '0;
            enable_q <= '0;
            in_service_q <= '0;
            rsp_valid_o <= 1'b0;
            ext_irq_o <= 1'b0;
        end else begin
            // Level gateway. A source in service cannot become pending.
            pending_q <= src_i & ~in_service_d;
            in_service_q <= in_service_d;
            rsp_valid_o <= hit;
            ext_irq_o <= |pend_en;
            if (hit && req_i.write && req_i.op == soc_periph_pkg::OP_ENABLE) begin
                enable_q <= en_new[N_SOURCES:1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            rsp_o.rdata <= rd_data;
            rsp_o.err <= rd_err;
        end
    end

endmodule

`default_nettype wire

/* hw/soc_periph_pkg.sv */
`default_nettype none

package soc_periph_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 16;
    localparam int STRB_W = DATA_W / 8;
    // The address bits above the offset select the unit.
    localparam int OFS_W = 12;

    localparam logic [ADDR_W-1:0] CLINT_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] PLIC_BASE = 16'h1000;

    localparam logic [OFS_W-1:0] OFS_MSIP = 12'h000;
    localparam logic [OFS_W-1:0] OFS_MTIMECMP_LO = 12'h008;
    localparam logic [OFS_W-1:0] OFS_MTIMECMP_HI = 12'h00C;
    localparam logic [OFS_W-1:0] OFS_MTIME_LO = 12'h010;
    localparam logic [OFS_W-1:0] OFS_MTIME_HI = 12'h014;
    localparam logic [OFS_W-1:0] OFS_PENDING = 12'h000;
    localparam logic [OFS_W-1:0] OFS_ENABLE = 12'h004;
    localparam logic [OFS_W-1:0] OFS_CLAIM = 12'h008;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'd0,
        RESP_SLVERR = 2'd2,
        RESP_DECERR = 2'd3
    } axi_resp_e;

    typedef struct packed {
        logic [ADDR_W-1:0] aw_addr;
        logic aw_valid;
        logic [DATA_W-1:0] w_data;
        logic [STRB_W-1:0] w_strb;
        logic w_valid;
        logic b_ready;
        logic [ADDR_W-1:0] ar_addr;
        logic ar_valid;
        logic r_ready;
    } axil_req_t;

    typedef struct packed {
        logic aw_ready;
        logic w_ready;
        logic b_valid;
        axi_resp_e b_resp;
        logic ar_ready;
        logic r_valid;
        logic [DATA_W-1:0] r_data;
        axi_resp_e r_resp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        UNIT_CLINT,
        UNIT_PLIC,
        UNIT_NONE
    } periph_unit_e;

    typedef enum logic [3:0] {
        OP_MSIP,
        OP_MTIMECMP_LO,
        OP_MTIMECMP_HI,
        OP_MTIME_LO,
        OP_MTIME_HI,
        OP_PENDING,
        OP_ENABLE,
        OP_CLAIM,
        OP_INVALID
    } periph_op_e;

    typedef struct packed {
        periph_unit_e unit;
        periph_op_e op;
        logic write;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } periph_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic err;
    } periph_rsp_t;

    // Merges a write into a register value, one byte per strobe bit.
    function automatic logic [DATA_W-1:0] apply_strb(
        input logic [DATA_W-1:0] old_val,
        input logic [DATA_W-1:0] new_val,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] res;
        res = old_val;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* hw/soc_periph_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
    parameter int N_SOURCES = 8,
    parameter int TICK_DIV = 4
) (
    input wire clk,
    input wire rst_n_i,
    input wire soc_periph_pkg::axil_req_t axil_req_i,
    output soc_periph_pkg::axil_rsp_t axil_rsp_o,
    input wire [N_SOURCES-1:0] src_i,
    output logic timer_irq_o,
    output logic soft_irq_o,
    output logic ext_irq_o
);

    logic aw_ready;
    logic w_ready;
    logic ar_ready;
    logic done;
    soc_periph_pkg::periph_req_t req;
    logic req_valid;
    soc_periph_pkg::periph_rsp_t clint_rsp;
    logic clint_rsp_valid;
    soc_periph_pkg::periph_rsp_t plic_rsp;
    logic plic_rsp_valid;
    logic b_valid;
    soc_periph_pkg::axi_resp_e b_resp;
    logic r_valid;
    logic [soc_periph_pkg::DATA_W-1:0] r_data;
    soc_periph_pkg::axi_resp_e r_resp;

    periph_decode u_decode (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .axil_req_i(axil_req_i),
        .aw_ready_o(aw_ready),
        .w_ready_o(w_ready),
        .ar_ready_o(ar_ready),
        .done_i(done),
        .req_o(req),
        .req_valid_o(req_valid)
    );

    clint_timer #(
        .TICK_DIV(TICK_DIV)
    ) u_clint (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .req_i(req),
        .req_valid_i(req_valid),
        .rsp_o(clint_rsp),
        .rsp_valid_o(clint_rsp_valid),
        .timer_irq_o(timer_irq_o),
        .soft_irq_o(soft_irq_o)
    );

    plic_gateway #(
        .N_SOURCES(N_SOURCES)
    ) u_plic (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .req_i(req),
        .req_valid_i(req_valid),
        .rsp_o(plic_rsp),
        .rsp_valid_o(plic_rsp_valid),
        .src_i(src_i),
        .ext_irq_o(ext_irq_o)
    );

    periph_result u_result (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .req_i(req),
        .req_valid_i(req_valid),
        .clint_rsp_i(clint_rsp),
        .clint_rsp_valid_i(clint_rsp_valid),
        .plic_rsp_i(plic_rsp),
        .plic_rsp_valid_i(plic_rsp_valid),
        .b_ready_i(axil_req_i.b_ready),
        .r_ready_i(axil_req_i.r_ready),
        .b_valid_o(b_valid),
        .b_resp_o(b_resp),
        .r_valid_o(r_valid),
        .r_data_o(r_data),
        .r_resp_o(r_resp),
        .done_o(done)
    );

    assign axil_rsp_o = '{
        aw_ready: aw_ready,
        w_ready: w_ready,
        b_valid: b_valid,
        b_resp: b_resp,
        ar_ready: ar_ready,
        r_valid: r_valid,
        r_data: r_data,
        r_resp: r_resp
    };

endmodule

`default_nettype wire

/* soc_periph_top.f */
hw/soc_periph_pkg.sv
hw/periph_decode.sv
hw/clint_timer.sv
hw/plic_gateway.sv
hw/periph_result.sv
hw/soc_periph_top.sv
test/tb_soc_periph.sv

/* test/soc_periph_tests.txt */
# name kind addr data strb src resp exp; all fields after kind are hex
# W,R,G check resp; R wants data == exp, G data >= exp; S drives src; I wants exp == {timer,soft,ext}
irq_after_reset   I 0000 00000000 0 00 0 00000000
msip_set          W 0000 00000001 f 00 0 00000000
msip_read         R 0000 00000000 0 00 0 00000001
soft_irq_on       I 0000 00000000 0 00 0 00000002
msip_clear        W 0000 00000000 f 00 0 00000000
soft_irq_off      I 0000 00000000 0 00 0 00000000
mtimecmp_lo_zero  W 0008 00000000 f 00 0 00000000
mtimecmp_hi_zero  W 000c 00000000 f 00 0 00000000
timer_irq_on      I 0000 00000000 0 00 0 00000004
mtime_lo_zero     W 0010 00000000 f 00 0 00000000
mtime_hi_zero     W 0014 00000000 f 00 0 00000000
mtimecmp_lo_ones  W 0008 ffffffff f 00 0 00000000
mtimecmp_hi_ones  W 000c ffffffff f 00 0 00000000
timer_irq_off     I 0000 00000000 0 00 0 00000000
mtime_lo_100      W 0010 00000064 f 00 0 00000000
mtime_lo_read     G 0010 00000000 0 00 0 00000064
mtimecmp_lo_strb  W 0008 a5a5a5a5 5 00 0 00000000
mtimecmp_lo_merge R 0008 00000000 0 00 0 ffa5ffa5
enable_2_5        W 1004 00000024 f 00 0 00000000
enable_read       R 1004 00000000 0 00 0 00000024
src_2_5_high      S 0000 00000000 0 12 0 00000000
ext_irq_on        I 0000 00000000 0 00 0 00000001
claim_first       R 1008 00000000 0 00 0 00000002
claim_second      R 1008 00000000 0 00 0 00000005
claim_empty       R 1008 00000000 0 00 0 00000000
src_2_5_low       S 0000 00000000 0 00 0 00000000
complete_2        W 1008 00000002 f 00 0 00000000
complete_5        W 1008 00000005 f 00 0 00000000
ext_irq_off       I 0000 00000000 0 00 0 00000000
enable_clear      W 1004 00000000 f 00 0 00000000
src_3_high        S 0000 00000000 0 04 0 00000000
pending_masked    R 1000 00000000 0 00 0 00000008
ext_irq_masked    I 0000 00000000 0 00 0 00000000
claim_masked      R 1008 00000000 0 00 0 00000000
unmapped_write    W 3000 12345678 f 00 3 00000000
unmapped_read     R 3000 00000000 0 00 3 00000000
clint_bad_offset  R 0020 00000000 0 00 2 00000000
pending_write     W 1000 ffffffff f 00 2 00000000
pending_kept      R 1000 00000000 0 00 0 00000008
src_3_low         S 0000 00000000 0 00 0 00000000
irq_all_low       I 0000 00000000 0 00 0 00000000

/* test/tb_soc_periph.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

    localparam int N_SOURCES = 8;
    localparam int TICK_DIV = 4;
    localparam int CYCLES_PER_LINE = 200;

    logic clk;
    logic rst_n;
    soc_periph_pkg::axil_req_t req;
    soc_periph_pkg::axil_rsp_t rsp;
    logic [N_SOURCES-1:0] src;
    logic timer_irq;
    logic soft_irq;
    logic ext_irq;
    logic [31:0] lfsr_state;
    int cycle_limit;

    soc_periph_top #(
        .N_SOURCES(N_SOURCES),
        .TICK_DIV(TICK_DIV)
    ) uut (
        .clk(clk),
        .rst_n_i(rst_n),
        .axil_req_i(req),
        .axil_rsp_o(rsp),
        .src_i(src),
        .timer_irq_o(timer_irq),
        .soft_irq_o(soft_irq),
        .ext_irq_o(ext_irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
    endtask

    task automatic check_value(input string step, input logic [31:0] expected,
                               input logic [31:0] actual, input bit at_least);
        logic ok;
        ok = at_least ? (actual >= expected) : (actual === expected);
        if (ok !== 1'b1) begin
            $display("[ERROR] %s: expected %s%h, actual %h", step,
                     at_least ? "at least " : "", expected, actual);
            $display("TEST FAILED");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // W may trail AW by a few cycles, and B is taken only after a random wait.
    task automatic write_access(input string name, input logic [15:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                output logic [1:0] resp);
        int gap;
        int hold;
        random_bits(2, gap);
        random_bits(3, hold);
        @(posedge clk);
        req.aw_addr <= addr;
        req.aw_valid <= 1'b1;
        repeat (gap) @(posedge clk);
        req.w_data <= data;
        req.w_strb <= strb;
        req.w_valid <= 1'b1;
        do @(posedge clk); while (rsp.aw_ready !== 1'b1 && rsp.w_ready !== 1'b1);
        // AW and W are accepted together.
        check_value({name, " aw/w ready"}, 32'd3, {rsp.aw_ready, rsp.w_ready}, 1'b0);
        req.aw_valid <= 1'b0;
        req.w_valid <= 1'b0;
        repeat (hold) @(posedge clk);
        req.b_ready <= 1'b1;
        do @(posedge clk); while (rsp.b_valid !== 1'b1);
        resp = rsp.b_resp;
        req.b_ready <= 1'b0;
    endtask

    task automatic read_access(input logic [15:0] addr, output logic [31:0] data,
                               output logic [1:0] resp);
        int hold;
        random_bits(3, hold);
        @(posedge clk);
        req.ar_addr <= addr;
        req.ar_valid <= 1'b1;
        do @(posedge clk); while (rsp.ar_ready !== 1'b1);
        req.ar_valid <= 1'b0;
        repeat (hold) @(posedge clk);
        req.r_ready <= 1'b1;
        do @(posedge clk); while (rsp.r_valid !== 1'b1);
        data = rsp.r_data;
        resp = rsp.r_resp;
        req.r_ready <= 1'b0;
    endtask

    task automatic run_step(input string name, input string kind, input logic [15:0] addr,
                            input logic [31:0] data, input logic [3:0] strb,
                            input logic [N_SOURCES-1:0] src_val, input logic [1:0] resp_exp,
                            input logic [31:0] exp_val);
        logic [31:0] got_data;
        logic [1:0] got_resp;
        if (kind == "W") begin
            write_access(name, addr, data, strb, got_resp);
            check_value({name, " resp"}, resp_exp, got_resp, 1'b0);
        end else if (kind == "R" || kind == "G") begin
            read_access(addr, got_data, got_resp);
            check_value({name, " resp"}, resp_exp, got_resp, 1'b0);
            check_value({name, " data"}, exp_val, got_data, kind == "G");
        end else if (kind == "S") begin
            @(posedge clk);
            src <= src_val;
        end else if (kind == "I") begin
            // The bus is idle here, and every interrupt output is one register stage late.
            repeat (4) @(posedge clk);
            check_value(name, exp_val, {timer_irq, soft_irq, ext_irq}, 1'b0);
        end else begin
            $display("Step %s has the unknown kind %s.", name, kind);
            $display("TEST FAILED");
            $fatal(1, "Bad test file.");
        end
    endtask

    initial begin
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clock cycles.", cycle_limit);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        int fd;
        int code;
        int ch;
        int line_count;
        string name;
        string kind;
        logic [15:0] addr;
        logic [31:0] data;
        logic [3:0] strb;
        logic [N_SOURCES-1:0] src_val;
        logic [1:0] resp_exp;
        logic [31:0] exp_val;

        req = '0;
        src = '0;
        rst_n = 1'b0;
        lfsr_state = 32'hdc65_8be0;
        line_count = 0;

        fd = $fopen("test/soc_periph_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file test/soc_periph_tests.txt.");
            $display("TEST FAILED");
            $fatal(1, "Missing test file.");
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            if (ch == 10) begin
                line_count++;
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        cycle_limit = CYCLES_PER_LINE * (line_count + 1);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        fd = $fopen("test/soc_periph_tests.txt", "r");
        code = $fscanf(fd, "%s", name);
        while (code == 1) begin
            if (name.substr(0, 0) == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                code = $fscanf(fd, "%s %h %h %h %h %h %h", kind, addr, data, strb,
                               src_val, resp_exp, exp_val);
                if (code != 7) begin
                    $display("Step %s in the test file has missing or bad fields.", name);
                    $display("TEST FAILED");
                    $fatal(1, "Bad test file.");
                end
                run_step(name, kind, addr, data, strb, src_val, resp_exp, exp_val);
            end
            code = $fscanf(fd, "%s", name);
        end
        $fclose(fd);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
